// ==== logic/spi_cfg_pkg.sv ====
`default_nettype none

package spi_cfg_pkg;

  // **************************************************
  // Word sizes
  // **************************************************
  parameter int CMD_WIDTH  = 12;
  parameter int READ_WIDTH = 8;

  // Frame lengths, counted in sclk rising edges
  parameter int WR_BITS = CMD_WIDTH;   // Whole command goes out
  parameter int RD_BITS = READ_WIDTH;  // Extra edges on a read

  // **************************************************
  // Top level defaults
  // **************************************************
  parameter int DEF_CLK_DIV    = 4;  // sclk half period in clk cycles
  parameter int DEF_FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// ==== logic/spi_cmd_pkg.sv ====
`default_nettype none

package spi_cmd_pkg;

  // **************************************************
  // Payload types
  // **************************************************
  typedef logic [spi_cfg_pkg::CMD_WIDTH-1:0]  cmd_t;
  typedef logic [spi_cfg_pkg::READ_WIDTH-1:0] read_t;

  // Command word layout
  //   [11]   frame type
  //   [10:8] address
  //   [7:0]  data
  parameter int RW_BIT   = 11;  // 1 write, 0 read

  parameter int ADDR_MSB = 10;
  parameter int ADDR_LSB = 8;

  parameter int DATA_MSB = 7;
  parameter int DATA_LSB = 0;

endpackage

`default_nettype wire

// ==== logic/spi_cmd_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  spi_cmd_pkg::cmd_t wdata,
  output logic              ready,
  input  logic              pop,
  output spi_cmd_pkg::cmd_t head,
  output logic              not_empty
);

  import spi_cmd_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  cmd_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= wdata;
  end

  assign head      = mem[rd_ptr];  // Show-ahead
  assign ready     = (count != CNT_W'(FIFO_DEPTH));
  assign not_empty = (count != '0);

  // **************************************************
  // Checks
  // **************************************************
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) push |-> ready
  ) else $error("FIFO push while full");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> not_empty
  ) else $error("FIFO pop while empty");

endmodule

`default_nettype wire

// ==== logic/spi_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_clk_gen #(
  parameter int CLK_DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic rise_stb,
  output logic fall_stb
);

  localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [CNT_W-1:0] cnt;
  logic             wrap;

  assign wrap = (cnt == CNT_W'(CLK_DIV - 1));

  // Strobes line up with the sclk edge they mark
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt      <= '0;
      sclk     <= 1'b0;
      rise_stb <= 1'b0;
      fall_stb <= 1'b0;
    end
    else if (!run)
    begin
      cnt      <= '0;    // Next frame starts a full half period out
      sclk     <= 1'b0;
      rise_stb <= 1'b0;
      fall_stb <= 1'b0;
    end
    else
    begin
      rise_stb <= wrap && !sclk;
      fall_stb <= wrap && sclk;
      if (wrap)
      begin
        cnt  <= '0;
        sclk <= ~sclk;
      end
      else
        cnt <= cnt + 1'b1;
    end
  end

  // **************************************************
  // Checks
  // **************************************************
  a_one_stb: assert property (
    @(posedge clk) disable iff (!rst_n) !(rise_stb && fall_stb)
  ) else $error("sclk rise and fall strobes together");

endmodule

`default_nettype wire

// ==== logic/spi_shift_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_shift_engine #(
  parameter int CLK_DIV = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_cmd_pkg::cmd_t  head,
  input  logic               not_empty,
  output logic               pop,
  output logic               run,
  input  logic               rise_stb,
  input  logic               fall_stb,
  output logic               cs,
  output logic               mosi,
  input  logic               miso,
  output logic               read_vld,
  output spi_cmd_pkg::read_t read_data
);

  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;

  localparam int BIT_W = $clog2(WR_BITS);
  localparam int GAP_W = $clog2(CLK_DIV + 1);

  typedef enum logic [1:0] {
    IDLE,
    SHIFT_OUT,
    SHIFT_IN,
    FINISH
  } state_t;

  state_t           state_cs;
  state_t           state_ns;
  cmd_t             sh;
  logic [BIT_W-1:0] bit_cnt;
  logic [GAP_W-1:0] gap_cnt;   // cs high time between frames
  logic             is_read;
  logic             last_out;
  logic             last_in;

  assign pop      = (state_cs == IDLE) && not_empty && (gap_cnt == '0);
  assign last_out = rise_stb && (bit_cnt == BIT_W'(WR_BITS - 1));
  assign last_in  = rise_stb && (bit_cnt == BIT_W'(RD_BITS - 1));

  // **************************************************
  // FSM
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_cs <= IDLE;
    else
      state_cs <= state_ns;
  end

  always_comb
  begin
    state_ns = state_cs;
    case (state_cs)
      IDLE:
        if (pop)
          state_ns = SHIFT_OUT;
      SHIFT_OUT:
        if (last_out)
          state_ns = is_read ? SHIFT_IN : FINISH;
      SHIFT_IN:
        if (last_in)
          state_ns = FINISH;
      FINISH:
        if (fall_stb)  // Closing falling edge
          state_ns = IDLE;
      default:
        state_ns = IDLE;
    endcase
  end

  // Frame control and pins
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cs       <= 1'b1;
      run      <= 1'b0;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      is_read  <= 1'b0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state_cs)
        IDLE:
        begin
          if (gap_cnt != '0)
            gap_cnt <= gap_cnt - 1'b1;
          if (pop)
          begin
            cs      <= 1'b0;
            run     <= 1'b1;
            mosi    <= head[CMD_WIDTH-1];  // MSB first
            is_read <= !head[RW_BIT];
            bit_cnt <= '0;
          end
        end
        SHIFT_OUT:
        begin
          if (fall_stb)
            mosi <= sh[CMD_WIDTH-2];
          if (last_out)
            bit_cnt <= '0;
          else if (rise_stb)
            bit_cnt <= bit_cnt + 1'b1;
        end
        SHIFT_IN:
        begin
          if (fall_stb)
            mosi <= 1'b0;
          if (rise_stb)
            bit_cnt <= bit_cnt + 1'b1;
          if (last_in)
            read_vld <= 1'b1;  // Byte complete next cycle
        end
        FINISH:
        begin
          if (fall_stb)
          begin
            cs      <= 1'b1;
            run     <= 1'b0;
            mosi    <= 1'b0;
            gap_cnt <= GAP_W'(CLK_DIV);
          end
        end
        default:
        begin
          cs  <= 1'b1;
          run <= 1'b0;
        end
      endcase
    end
  end

  // Data shift registers
  always_ff @(posedge clk)
  begin
    if (pop)
      sh <= head;
    else if ((state_cs == SHIFT_OUT) && fall_stb)
      sh <= {sh[CMD_WIDTH-2:0], 1'b0};
    if ((state_cs == SHIFT_IN) && rise_stb)
      read_data <= {read_data[READ_WIDTH-2:0], miso};
  end

  // **************************************************
  // Checks
  // **************************************************
  a_pop_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> (state_cs == IDLE) && not_empty && cs && !run
  ) else $error("Command pop outside an idle bus");

  a_read_vld: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_vld |-> is_read && !cs && $past(rise_stb)
  ) else $error("read_vld outside a read frame");

endmodule

`default_nettype wire

// ==== logic/spi_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module spi_ctrl_top #(
  parameter int CLK_DIV    = spi_cfg_pkg::DEF_CLK_DIV,
  parameter int FIFO_DEPTH = spi_cfg_pkg::DEF_FIFO_DEPTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  spi_cmd_pkg::cmd_t  cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  output logic               sclk,
  output logic               cs,
  output logic               mosi,
  input  logic               miso,
  output logic               read_vld,
  output spi_cmd_pkg::read_t read_data
);

  import spi_cmd_pkg::*;

  cmd_t head;
  logic push;
  logic pop;
  logic not_empty;
  logic run;
  logic rise_stb;
  logic fall_stb;

  assign push = cmd_vld && cmd_rdy;  // Accepted word

  spi_cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) spi_cmd_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .wdata     (cmd_in),
    .ready     (cmd_rdy),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty)
  );

  spi_clk_gen #(
    .CLK_DIV (CLK_DIV)
  ) spi_clk_gen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .sclk     (sclk),
    .rise_stb (rise_stb),
    .fall_stb (fall_stb)
  );

  spi_shift_engine #(
    .CLK_DIV (CLK_DIV)
  ) spi_shift_engine_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop),
    .run       (run),
    .rise_stb  (rise_stb),
    .fall_stb  (fall_stb),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

// ==== tb/tb_spi_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_spi_ctrl;

  import spi_cfg_pkg::*;
  import spi_cmd_pkg::*;

  localparam int CLK_DIV    = DEF_CLK_DIV;
  localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
  localparam int PERIOD     = 8;
  localparam int MAX_GAP    = 40;  // Idle cycles between commands
  localparam int BURST_LEN  = 7;   // Trailing commands sent back to back

  logic  clk;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  cmd_rdy;
  logic  sclk;
  logic  cs;
  logic  mosi;
  logic  miso;
  logic  read_vld;
  read_t read_data;

  cmd_t   trace_cmd[$];
  read_t  trace_miso[$];
  read_t  trace_exp[$];
  cmd_t   accepted_q[$];
  logic   trace_loaded = 1'b0;
  logic   in_burst = 1'b0;
  int     n_reads = 0;
  int     burst_stalls = 0;
  int     frames_done = 0;
  int     reads_seen = 0;
  int     gap;
  longint limit_ns;

  // Frame monitor state
  logic prev_cs = 1'b1;
  logic prev_sclk = 1'b0;
  logic in_frame = 1'b0;
  cmd_t cap;
  int   rise_cnt;
  int   vld_cnt;
  int   miso_idx;

  spi_ctrl_top #(
    .CLK_DIV    (CLK_DIV),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) spi_ctrl_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // **************************************************
  // Compare tasks
  // **************************************************
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_read(input string name, input read_t got, input read_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic read_trace();
    int    fd;
    int    n;
    string line;
    cmd_t  c;
    read_t m;
    read_t e;
    fd = $fopen("tb/spi_trace.txt", "r");
    if (fd == 0)
      fail_run("cannot open the trace file tb/spi_trace.txt");
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() == 0 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%h %h %h", c, m, e);
      if (n == 3)
      begin
        trace_cmd.push_back(c);
        trace_miso.push_back(m);
        trace_exp.push_back(e);
        if (!c[RW_BIT])
          n_reads++;  // Bit 11 low is a read
      end
    end
    $fclose(fd);
    if (trace_cmd.size() == 0)
      fail_run("trace file holds no commands");
    trace_loaded = 1'b1;
  endtask

  // Holds the word until the FIFO takes it
  task automatic send_cmd(input cmd_t word, input int idle);
    logic taken;
    cmd_vld = 1'b0;
    repeat (idle) @(negedge clk);
    cmd_in  = word;
    cmd_vld = 1'b1;
    taken   = 1'b0;
    while (!taken)
    begin
      taken = cmd_rdy;
      if (taken)
        accepted_q.push_back(word);
      else if (in_burst)
        burst_stalls++;
      @(negedge clk);
    end
  endtask

  // **************************************************
  // SPI slave model and frame monitor
  // **************************************************
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (cs)
        check_bit("sclk", sclk, 1'b0);
      if (prev_cs && !cs)
      begin
        if (frames_done >= trace_cmd.size())
          fail_run("more SPI frames than trace lines");
        in_frame = 1'b1;
        rise_cnt = 0;
        vld_cnt  = 0;
        miso_idx = -1;
        cap      = '0;
      end
      if (!cs && sclk && !prev_sclk)
      begin
        rise_cnt++;
        if (rise_cnt <= WR_BITS)
          cap = {cap[CMD_WIDTH-2:0], mosi};
        if (rise_cnt == WR_BITS && !cap[RW_BIT])
        begin
          miso     = trace_miso[frames_done][READ_WIDTH-1];
          miso_idx = READ_WIDTH - 2;
        end
      end
      if (!cs && !sclk && prev_sclk && rise_cnt > WR_BITS && miso_idx >= 0)
      begin
        miso = trace_miso[frames_done][miso_idx];
        miso_idx--;
      end
      if (read_vld)
      begin
        if (!in_frame || cap[RW_BIT])
          fail_run("read_vld pulse outside a read frame");
        check_count("sclk rises at read_vld", rise_cnt, WR_BITS + RD_BITS);
        check_read("read_data", read_data, trace_exp[frames_done]);
        vld_cnt++;
        reads_seen++;
      end
      if (!prev_cs && cs)
      begin
        if (accepted_q.size() == 0)
          fail_run("SPI frame seen with no accepted command");
        check_cmd("frame word", cap, accepted_q[0]);
        check_count("sclk rises", rise_cnt, accepted_q[0][RW_BIT] ? WR_BITS : WR_BITS + RD_BITS);
        check_count("read_vld pulses", vld_cnt, accepted_q[0][RW_BIT] ? 0 : 1);
        void'(accepted_q.pop_front());
        in_frame = 1'b0;
        miso     = 1'b0;
        frames_done++;
      end
    end
    prev_cs   = cs;
    prev_sclk = sclk;
  end

  // Worst case frame is a read, 41 half periods, plus cs gap and source idle time
  initial
  begin
    wait (trace_loaded);
    limit_ns = (trace_cmd.size() * (41 * CLK_DIV + CLK_DIV + MAX_GAP + 4) + 64) * PERIOD;
    #(limit_ns);
    fail_run("timeout, SPI frames did not all finish");
  end

  initial
  begin
    void'($urandom(32'heb3e));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    miso    = 1'b0;
    read_trace();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);
    check_bit("cs", cs, 1'b1);
    check_bit("sclk", sclk, 1'b0);
    check_bit("mosi", mosi, 1'b0);
    check_bit("read_vld", read_vld, 1'b0);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    for (int i = 0; i < trace_cmd.size(); i++)
    begin
      if (i >= trace_cmd.size() - BURST_LEN)
        in_burst = 1'b1;
      gap = in_burst ? 0 : $urandom % (MAX_GAP + 1);
      send_cmd(trace_cmd[i], gap);
    end
    cmd_vld  = 1'b0;
    in_burst = 1'b0;
    wait (frames_done == trace_cmd.size());
    repeat (4 * CLK_DIV) @(negedge clk);
    check_count("read results", reads_seen, n_reads);
    if (burst_stalls == 0)
      fail_run("cmd_rdy never went low during the command burst");
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tb/spi_trace.txt ====
# command word, miso byte returned by the slave, expected read_data (all hex)
# bit 11 of the command set means a write, miso and expected are 00 there
a5c 00 00
312 3c 3c
8ff 00 00
000 a5 a5
f01 00 00
7aa 5a 5a
1c3 ff ff
c80 00 00
255 00 00
9e7 00 00
6b4 81 81
5f0 c3 c3
e99 00 00
0fe 18 18
a00 00 00
3a7 e4 e4
d3d 00 00
41f 7e 7e

// ==== files.f ====
logic/spi_cfg_pkg.sv
logic/spi_cmd_pkg.sv
logic/spi_cmd_fifo.sv
logic/spi_clk_gen.sv
logic/spi_shift_engine.sv
logic/spi_ctrl_top.sv
tb/tb_spi_ctrl.sv
